// ==== project.f ====
busPkg.sv
devPkg.sv
displayDevice.sv
debouncedInput.sv
intervalTimer.sv
ioReturnPath.sv
ioTop.sv
tbIo.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tbIo -o simIo

# the log decides the result, so a failing run must not stop the script here
./obj_dir/simIo > sim.log 2>&1 || true
cat sim.log

if grep -q '^=== PASS ===$' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== tbIo.sv ====
`timescale 1ns/10ps
`default_nettype none

module tbIo;
  import busPkg::*;
  import devPkg::*;

  localparam int POLL_LIMIT  = 100;
  localparam int CYCLE_LIMIT = 400;

  localparam addr_t KEY_CTRL   = ADDR_KEY + CTRL_OFFSET;
  localparam addr_t SW_CTRL    = ADDR_SW + CTRL_OFFSET;
  localparam addr_t TIMER_LIM  = ADDR_TIMER + CTRL_OFFSET;
  localparam addr_t TIMER_CTRL = ADDR_TIMER + 2 * CTRL_OFFSET;

  logic                  clk = 1'b0;
  logic                  reset;
  busReq_t               bus;
  logic [KEY_BITS-1:0]   key;
  logic [SW_BITS-1:0]    sw;
  word_t                 rdData;
  segDisplay_t           hex;
  logic [LEDR_BITS-1:0]  ledr;
  logic                  irq;
  irqId_t                irqId;

  // display model, follows every write the DUT has taken
  hexValue_t  expHex = HEX_RESET;
  ledrValue_t expLedr = '0;
  logic       displayLive = 1'b0;
  word_t      rngState = 32'd12445;

  ioTop #(
    .keyPeriod (4),
    .swPeriod  (8),
    .msTicks   (5)
  ) u_dut (
    .clk    (clk),
    .reset  (reset),
    .bus    (bus),
    .key    (key),
    .sw     (sw),
    .rdData (rdData),
    .hex    (hex),
    .ledr   (ledr),
    .irq    (irq),
    .irqId  (irqId)
  );

  always #10 clk = ~clk;

  // 32-bit xorshift
  function automatic word_t nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // lit segments per digit, bit 0 is segment a, then inverted for the board
  function automatic segment_t segRef(input nibble_t value);
    logic [6:0] lit;
    case (value)
      4'h0: lit = 7'h3F;
      4'h1: lit = 7'h06;
      4'h2: lit = 7'h5B;
      4'h3: lit = 7'h4F;
      4'h4: lit = 7'h66;
      4'h5: lit = 7'h6D;
      4'h6: lit = 7'h7D;
      4'h7: lit = 7'h07;
      4'h8: lit = 7'h7F;
      4'h9: lit = 7'h6F;
      4'hA: lit = 7'h77;
      4'hB: lit = 7'h7C;
      4'hC: lit = 7'h39;
      4'hD: lit = 7'h5E;
      4'hE: lit = 7'h79;
      default: lit = 7'h71;
    endcase
    return ~lit;
  endfunction

  task automatic check(input string name, input word_t got, input word_t expected);
    if (got !== expected) begin
      $display("Fail at time %0t: %s is %h, expected %h", $time, name, got, expected);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic stopOnTimeout(input string what);
    $display("Timed out at time %0t while waiting for %s", $time, what);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic checkDisplay();
    logic [7*HEX_DIGITS-1:0] hexBits;
    nibble_t                 nib;
    hexBits = hex;
    // digit0 sits in the low bits of the struct
    for (int d = 0; d < HEX_DIGITS; d++) begin
      nib = expHex[4*d +: 4];
      check($sformatf("hex digit%0d", d), word_t'(hexBits[7*d +: 7]), word_t'(segRef(nib)));
    end
    check("ledr", word_t'(ledr), word_t'(expLedr));
  endtask

  task automatic busWrite(input addr_t addr, input word_t data);
    busReq_t req;
    req = '0;
    req.addr = addr;
    req.wrData = data;
    req.we = 1'b1;
    @(posedge clk);
    bus <= req;
    @(posedge clk);
    // DUT registers took the write at this edge
    if (addr == ADDR_HEX) begin
      expHex = data[HEX_BITS-1:0];
    end
    if (addr == ADDR_LEDR) begin
      expLedr = data[LEDR_BITS-1:0];
    end
    bus <= '0;
  endtask

  task automatic busRead(input addr_t addr, output word_t data);
    busReq_t req;
    req = '0;
    req.addr = addr;
    req.re = 1'b1;
    @(posedge clk);
    bus <= req;
    // combinational read data, settled mid cycle
    @(negedge clk);
    data = rdData;
    @(posedge clk);
    bus <= '0;
  endtask

  task automatic waitCtrlBit(input addr_t addr, input int bitPos, input string what);
    word_t value;
    int    polls;
    polls = 0;
    busRead(addr, value);
    while (!value[bitPos]) begin
      polls++;
      if (polls > POLL_LIMIT) begin
        stopOnTimeout(what);
      end
      busRead(addr, value);
    end
  endtask

  task automatic waitIrq(input string what);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!irq) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
        stopOnTimeout(what);
      end
      @(negedge clk);
    end
  endtask

  // display outputs against the model on every falling edge
  always @(negedge clk) begin
    if (displayLive) begin
      checkDisplay();
    end
  end

  initial begin
    word_t               got;
    word_t               hexVal;
    word_t               ledrVal;
    word_t               rnd;
    logic [SW_BITS-1:0]  swValue;
    logic [KEY_BITS-1:0] keyNow;
    logic [KEY_BITS-1:0] pressed;

    reset <= 1'b1;
    bus <= '0;
    key <= '1;
    sw <= '0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    displayLive = 1'b1;

    // reset values and display writes
    checkDisplay();
    for (int i = 0; i < 6; i++) begin
      hexVal = nextRandom();
      ledrVal = nextRandom();
      busWrite(ADDR_HEX, hexVal);
      busWrite(ADDR_LEDR, ledrVal);
      @(negedge clk);
      checkDisplay();
      busRead(ADDR_HEX, got);
      check("HEX readback", got, word_t'(hexVal[HEX_BITS-1:0]));
      busRead(ADDR_LEDR, got);
      check("LEDR readback", got, word_t'(ledrVal[LEDR_BITS-1:0]));
    end
    busRead(ADDR_HEX + 32'd4, got);
    check("unmapped FFFFF004", got, '0);
    busRead(32'h0000_0000, got);
    check("unmapped 00000000", got, '0);
    busRead(ADDR_TIMER + 32'd12, got);
    check("unmapped FFFFF10C", got, '0);

    // switch debounce, never zero so a change is seen
    rnd = nextRandom();
    swValue = rnd[SW_BITS-1:0];
    if (swValue == '0) begin
      swValue = 10'h001;
    end
    @(posedge clk);
    sw <= swValue;
    waitCtrlBit(SW_CTRL, CTRL_READY, "switch ready");
    busRead(ADDR_SW, got);
    check("switch data", got, word_t'(swValue));
    busRead(SW_CTRL, got);
    check("switch ready after read", word_t'(got[CTRL_READY]), '0);

    // key bit 0 pressed, then bit 2 too without a read
    keyNow = 4'b1110;
    @(posedge clk);
    key <= keyNow;
    waitCtrlBit(KEY_CTRL, CTRL_READY, "key ready");
    keyNow = 4'b1010;
    @(posedge clk);
    key <= keyNow;
    waitCtrlBit(KEY_CTRL, CTRL_OVERRUN, "key overrun");
    pressed = ~keyNow;
    busRead(ADDR_KEY, got);
    check("key data", got, word_t'(pressed));
    busWrite(KEY_CTRL, '0);
    busRead(KEY_CTRL, got);
    check("key overrun after clear", word_t'(got[CTRL_OVERRUN]), '0);

    // timer with limit 3 and its interrupt on
    busWrite(TIMER_LIM, 32'd3);
    busWrite(TIMER_CTRL, word_t'(1) << CTRL_IE);
    waitIrq("timer interrupt");
    check("irqId", word_t'(irqId), 32'd1);
    busRead(TIMER_CTRL, got);
    check("timer ready", word_t'(got[CTRL_READY]), 32'd1);
    busWrite(TIMER_CTRL, word_t'(1) << CTRL_IE);
    @(negedge clk);
    check("irq after timer clear", word_t'(irq), '0);

    // key and timer pending together
    busWrite(KEY_CTRL, word_t'(1) << CTRL_IE);
    keyNow = 4'b1111;
    @(posedge clk);
    key <= keyNow;
    waitCtrlBit(KEY_CTRL, CTRL_READY, "key ready with interrupt on");
    waitCtrlBit(TIMER_CTRL, CTRL_READY, "timer ready again");
    @(negedge clk);
    check("irqId with timer and key", word_t'(irqId), 32'd1);
    busWrite(TIMER_CTRL, '0);
    @(negedge clk);
    check("irq with key only", word_t'(irq), 32'd1);
    check("irqId with key only", word_t'(irqId), 32'd2);
    busRead(ADDR_KEY, got);
    check("key data released", got, '0);
    @(negedge clk);
    check("irq after key read", word_t'(irq), '0);
    check("irqId after key read", word_t'(irqId), '0);

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== ioTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module ioTop #(
  parameter int keyPeriod = 16,
  parameter int swPeriod  = 4096,
  parameter int msTicks   = 100000
) (
  input  logic                         clk,
  input  logic                         reset,
  input  busPkg::busReq_t              bus,
  input  logic [devPkg::KEY_BITS-1:0]  key,
  input  logic [devPkg::SW_BITS-1:0]   sw,
  output busPkg::word_t                rdData,
  output devPkg::segDisplay_t          hex,
  output logic [devPkg::LEDR_BITS-1:0] ledr,
  output logic                         irq,
  output devPkg::irqId_t               irqId
);
  import busPkg::*;
  import devPkg::*;

  // per-device read data, zero when not addressed
  word_t displayData;
  word_t keyData;
  word_t swData;
  word_t timerData;

  // per-device interrupt requests
  logic keyIntr;
  logic swIntr;
  logic timerIntr;

  displayDevice u_display (
    .clk    (clk),
    .reset  (reset),
    .bus    (bus),
    .ledr   (ledr),
    .hex    (hex),
    .rdData (displayData)
  );

  // keys are wired active low on the board
  debouncedInput #(
    .WIDTH      (KEY_BITS),
    .BASE       (ADDR_KEY),
    .PERIOD     (keyPeriod),
    .ACTIVE_LOW (1'b1)
  ) u_keys (
    .clk    (clk),
    .reset  (reset),
    .bus    (bus),
    .pins   (key),
    .rdData (keyData),
    .intr   (keyIntr)
  );

  // switches bounce slower, so a longer sample period
  debouncedInput #(
    .WIDTH      (SW_BITS),
    .BASE       (ADDR_SW),
    .PERIOD     (swPeriod),
    .ACTIVE_LOW (1'b0)
  ) u_switches (
    .clk    (clk),
    .reset  (reset),
    .bus    (bus),
    .pins   (sw),
    .rdData (swData),
    .intr   (swIntr)
  );

  intervalTimer #(
    .BASE     (ADDR_TIMER),
    .MS_TICKS (msTicks)
  ) u_timer (
    .clk    (clk),
    .reset  (reset),
    .bus    (bus),
    .rdData (timerData),
    .intr   (timerIntr)
  );

  ioReturnPath u_return (
    .displayData (displayData),
    .keyData     (keyData),
    .swData      (swData),
    .timerData   (timerData),
    .keyIntr     (keyIntr),
    .swIntr      (swIntr),
    .timerIntr   (timerIntr),
    .rdData      (rdData),
    .irq         (irq),
    .irqId       (irqId)
  );

endmodule

`default_nettype wire

// ==== ioReturnPath.sv ====
`timescale 1ns/10ps
`default_nettype none

module ioReturnPath (
  input  busPkg::word_t  displayData,
  input  busPkg::word_t  keyData,
  input  busPkg::word_t  swData,
  input  busPkg::word_t  timerData,
  input  logic           keyIntr,
  input  logic           swIntr,
  input  logic           timerIntr,
  output busPkg::word_t  rdData,
  output logic           irq,
  output devPkg::irqId_t irqId
);
  import devPkg::*;

  // unselected devices drive zero, so OR is the mux
  assign rdData = displayData | keyData | swData | timerData;

  assign irq = timerIntr || keyIntr || swIntr;

  // timer first, then keys, then switches
  always_comb begin
    if (timerIntr) begin
      irqId = irqId_t'(1);
    end else if (keyIntr) begin
      irqId = irqId_t'(2);
    end else if (swIntr) begin
      irqId = irqId_t'(3);
    end else begin
      irqId = irqId_t'(0);
    end
  end

endmodule

`default_nettype wire

// ==== intervalTimer.sv ====
`timescale 1ns/10ps
`default_nettype none

module intervalTimer #(
  parameter busPkg::addr_t BASE     = 32'hFFFFF100,
  parameter int            MS_TICKS = 100000
) (
  input  logic            clk,
  input  logic            reset,
  input  busPkg::busReq_t bus,
  output busPkg::word_t   rdData,
  output logic            intr
);
  import busPkg::*;
  import devPkg::*;

  localparam int TICK_BITS = (MS_TICKS > 1) ? $clog2(MS_TICKS) : 1;

  typedef logic [TICK_BITS-1:0] tick_t;

  localparam tick_t LAST_TICK = tick_t'(MS_TICKS - 1);

  tick_t tickCnt;
  word_t countReg;
  word_t limitReg;
  word_t ctrlReg;
  logic  msTick;
  logic  selCount;
  logic  selLimit;
  logic  selCtrl;
  logic  ctrlWrite;
  logic  clrReady;
  logic  limitHit;

  assign selCount  = (bus.addr == BASE);
  assign selLimit  = (bus.addr == BASE + CTRL_OFFSET);
  assign selCtrl   = (bus.addr == BASE + 2 * CTRL_OFFSET);
  assign ctrlWrite = bus.we && selCtrl;
  assign clrReady  = ctrlWrite && !bus.wrData[CTRL_READY];

  // one millisecond worth of clocks
  assign msTick = (tickCnt == LAST_TICK);
  // limit of zero disables the match
  assign limitHit = (limitReg != '0) && (countReg >= limitReg);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tickCnt  <= '0;
      countReg <= '0;
      limitReg <= '0;
      ctrlReg  <= '0;
    end else begin
      if (msTick) begin
        tickCnt <= '0;
      end else begin
        tickCnt <= tickCnt + 1'b1;
      end
      // wrap on limit, else count milliseconds
      if (limitHit) begin
        countReg <= '0;
      end else if (msTick) begin
        countReg <= countReg + 1'b1;
      end
      // bus writes override the running count
      if (bus.we && selCount) begin
        countReg <= bus.wrData;
      end
      if (bus.we && selLimit) begin
        limitReg <= bus.wrData;
        countReg <= '0;
      end
      // ready and overrun clear on a written zero
      if (ctrlWrite) begin
        if (clrReady) begin
          ctrlReg[CTRL_READY] <= 1'b0;
        end
        if (!bus.wrData[CTRL_OVERRUN]) begin
          ctrlReg[CTRL_OVERRUN] <= 1'b0;
        end
        ctrlReg[CTRL_IE] <= bus.wrData[CTRL_IE];
      end
      // a limit match that meets a clear still counts as a new event
      if (limitHit) begin
        if (ctrlReg[CTRL_READY] && !clrReady) begin
          ctrlReg[CTRL_OVERRUN] <= 1'b1;
        end else begin
          ctrlReg[CTRL_READY] <= 1'b1;
        end
      end
    end
  end

  assign intr = ctrlReg[CTRL_READY] && ctrlReg[CTRL_IE];

  always_comb begin
    rdData = '0;
    if (bus.re) begin
      if (selCount) begin
        rdData = countReg;
      end else if (selLimit) begin
        rdData = limitReg;
      end else if (selCtrl) begin
        rdData = ctrlReg;
      end
    end
  end

endmodule

`default_nettype wire

// ==== debouncedInput.sv ====
`timescale 1ns/10ps
`default_nettype none

module debouncedInput #(
  parameter int            WIDTH      = 4,
  parameter busPkg::addr_t BASE       = 32'hFFFFF080,
  parameter int            PERIOD     = 16,
  parameter bit            ACTIVE_LOW = 1'b0
) (
  input  logic             clk,
  input  logic             reset,
  input  busPkg::busReq_t  bus,
  input  logic [WIDTH-1:0] pins,
  output busPkg::word_t    rdData,
  output logic             intr
);
  import busPkg::*;
  import devPkg::*;

  localparam int CNT_BITS = (PERIOD > 1) ? $clog2(PERIOD) : 1;

  typedef logic [WIDTH-1:0]    value_t;
  typedef logic [CNT_BITS-1:0] period_t;

  localparam period_t LAST_COUNT = period_t'(PERIOD - 1);

  period_t periodCnt;
  value_t  pinLevel;
  value_t  sample;
  value_t  lastSample;
  value_t  dataReg;
  word_t   ctrlReg;
  logic    sampleTick;
  logic    selData;
  logic    selCtrl;
  logic    dataRead;
  logic    ctrlWrite;
  logic    newValue;

  // pressed key reads as 1
  assign pinLevel = ACTIVE_LOW ? ~pins : pins;

  assign selData   = (bus.addr == BASE);
  assign selCtrl   = (bus.addr == BASE + CTRL_OFFSET);
  assign dataRead  = bus.re && selData;
  assign ctrlWrite = bus.we && selCtrl;

  // sample period ends
  assign sampleTick = (periodCnt == LAST_COUNT);
  // two equal samples that differ from what software last saw
  assign newValue = sampleTick && (lastSample == sample) && (sample != dataReg);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      periodCnt  <= '0;
      sample     <= '0;
      lastSample <= '0;
      dataReg    <= '0;
      ctrlReg    <= '0;
    end else begin
      if (sampleTick) begin
        periodCnt  <= '0;
        sample     <= pinLevel;
        lastSample <= sample;
      end else begin
        periodCnt <= periodCnt + 1'b1;
      end
      // data read consumes the value
      if (dataRead) begin
        ctrlReg[CTRL_READY] <= 1'b0;
      end
      // overrun is write-zero-to-clear
      if (ctrlWrite) begin
        if (!bus.wrData[CTRL_OVERRUN]) begin
          ctrlReg[CTRL_OVERRUN] <= 1'b0;
        end
        ctrlReg[CTRL_IE] <= bus.wrData[CTRL_IE];
      end
      // a fresh value wins over a same-cycle clear
      if (newValue) begin
        dataReg <= sample;
        if (ctrlReg[CTRL_READY] && !dataRead) begin
          ctrlReg[CTRL_OVERRUN] <= 1'b1;
        end else begin
          ctrlReg[CTRL_READY] <= 1'b1;
        end
      end
    end
  end

  assign intr = ctrlReg[CTRL_READY] && ctrlReg[CTRL_IE];

  always_comb begin
    rdData = '0;
    if (dataRead) begin
      rdData = word_t'(dataReg);
    end else if (bus.re && selCtrl) begin
      rdData = ctrlReg;
    end
  end

endmodule

`default_nettype wire

// ==== displayDevice.sv ====
`timescale 1ns/10ps
`default_nettype none

module displayDevice (
  input  logic                         clk,
  input  logic                         reset,
  input  busPkg::busReq_t              bus,
  output logic [devPkg::LEDR_BITS-1:0] ledr,
  output devPkg::segDisplay_t          hex,
  output busPkg::word_t                rdData
);
  import busPkg::*;
  import devPkg::*;

  ledrValue_t                ledrReg;
  hexValue_t                 hexReg;
  segment_t [HEX_DIGITS-1:0] segs;
  logic                      selLedr;
  logic                      selHex;

  // hex digit to active-low segments
  function automatic segment_t segDecode(input nibble_t nibble);
    segment_t pattern;
    case (nibble)
      4'h0: pattern = 7'b1000000;
      4'h1: pattern = 7'b1111001;
      4'h2: pattern = 7'b0100100;
      4'h3: pattern = 7'b0110000;
      4'h4: pattern = 7'b0011001;
      4'h5: pattern = 7'b0010010;
      4'h6: pattern = 7'b0000010;
      4'h7: pattern = 7'b1111000;
      4'h8: pattern = 7'b0000000;
      4'h9: pattern = 7'b0010000;
      4'hA: pattern = 7'b0001000;
      4'hB: pattern = 7'b0000011;
      4'hC: pattern = 7'b1000110;
      4'hD: pattern = 7'b0100001;
      4'hE: pattern = 7'b0000110;
      default: pattern = 7'b0001110;
    endcase
    return pattern;
  endfunction

  assign selLedr = (bus.addr == ADDR_LEDR);
  assign selHex  = (bus.addr == ADDR_HEX);

  // writes keep only the low bits
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ledrReg <= '0;
      hexReg  <= HEX_RESET;
    end else begin
      if (bus.we && selLedr) begin
        ledrReg <= bus.wrData[LEDR_BITS-1:0];
      end
      if (bus.we && selHex) begin
        hexReg <= bus.wrData[HEX_BITS-1:0];
      end
    end
  end

  // one decoder per nibble, digit0 from the low nibble
  for (genvar d = 0; d < HEX_DIGITS; d++) begin : gDigit
    assign segs[d] = segDecode(hexReg[4*d +: 4]);
  end

  assign hex  = segDisplay_t'(segs);
  assign ledr = ledrReg;

  // readback zero-extended
  always_comb begin
    rdData = '0;
    if (bus.re && selLedr) begin
      rdData = word_t'(ledrReg);
    end else if (bus.re && selHex) begin
      rdData = word_t'(hexReg);
    end
  end

endmodule

`default_nettype wire

// ==== devPkg.sv ====
`default_nettype none

package devPkg;

  // device field widths
  localparam int LEDR_BITS  = 10;
  localparam int HEX_BITS   = 24;
  localparam int HEX_DIGITS = 6;
  localparam int KEY_BITS   = 4;
  localparam int SW_BITS    = 10;

  // control register bit positions, shared by inputs and timer
  localparam int CTRL_READY   = 0;
  localparam int CTRL_OVERRUN = 1;
  localparam int CTRL_IE      = 4;

  typedef logic [LEDR_BITS-1:0] ledrValue_t;
  typedef logic [HEX_BITS-1:0]  hexValue_t;
  typedef logic [3:0]           nibble_t;

  // active low, bit 6 is segment g
  typedef logic [6:0] segment_t;

  // leftmost display digit first
  typedef struct packed {
    segment_t digit5;
    segment_t digit4;
    segment_t digit3;
    segment_t digit2;
    segment_t digit1;
    segment_t digit0;
  } segDisplay_t;

  // interrupt number, 0 means none pending
  typedef logic [1:0] irqId_t;

  localparam hexValue_t HEX_RESET = 24'hFEDEAD;

endpackage

`default_nettype wire

// ==== busPkg.sv ====
`default_nettype none

package busPkg;

  // one bus word and one byte address
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;

  // one bus cycle from the master, we and re never high together
  typedef struct packed {
    addr_t addr;
    word_t wrData;
    logic  we;
    logic  re;
  } busReq_t;

  // device address map
  localparam addr_t ADDR_HEX   = 32'hFFFFF000;
  localparam addr_t ADDR_LEDR  = 32'hFFFFF020;
  localparam addr_t ADDR_KEY   = 32'hFFFFF080;
  localparam addr_t ADDR_SW    = 32'hFFFFF090;
  // count here, limit at +4, control at +8
  localparam addr_t ADDR_TIMER = 32'hFFFFF100;

  // control register sits one word above its data register
  localparam addr_t CTRL_OFFSET = 32'd4;

endpackage

`default_nettype wire
